// ==== build.f ====
rtl/pecDimPkg.sv
rtl/pecBusPkg.sv
rtl/sparseMac.sv
rtl/convRow.sv
rtl/weightBank.sv
rtl/pecControl.sv
rtl/psumRamPort.sv
rtl/pecColumn.sv
tests/pecCheck_sva.sv
tests/tbPec.sv

// ==== Makefile ====
# Verilator flow for the PE column testbench

TOP := tbPec
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tbPec.sv ====
// Testbench for pecColumn; RAM model has one-cycle read latency, beats per block stay below RAM depth
`default_nettype none
`timescale 1ns/1ps

module tbPec
    import pecDimPkg::*;
    import pecBusPkg::*;
();

    localparam int RamAddrWidth = 6;
    localparam int RamDepth     = 1 << RamAddrWidth;
    // Stimulus shape, one weight load per block
    localparam int NumBlocks    = 3;
    localparam int RowsPerBlock = 3;
    localparam int BeatsPerRow  = 5;
    localparam int TotalBeats   = NumBlocks * RowsPerBlock * BeatsPerRow;

    logic                    clk;
    logic                    rst_n;
    logic                    rdyWei;
    logic                    getWei;
    weiSet_t                 weiIn;
    logic                    lstRdy;
    actBeat_t                lstBeat;
    logic                    lstGet;
    logic                    nxtRdy;
    actBeat_t                nxtBeat;
    logic                    nxtGet;
    logic                    ramEnRd;
    logic [RamAddrWidth-1:0] ramAddrRd;
    psum_t                   ramRdData;
    logic                    ramEnWr;
    logic [RamAddrWidth-1:0] ramAddrWr;
    psum_t                   ramWrData;

    int       seed = 73226;
    // RAM model contents and the expected view of them
    psum_t    ramMem [RamDepth];
    psum_t    shadowMem [RamDepth];
    // Next-column answer delays, drawn up front
    int       getDelay [TotalBeats];
    weiSet_t  curWei;
    // Beats since the last firstRow, index 0 newest
    actBeat_t hist [3];
    int       histDepth;
    int       rdAddr;
    int       wrAddr;
    actBeat_t sentQ [$];
    int       expRdAddr [$];
    int       expWrAddr [$];
    psum_t    expWrData [$];
    int       weiPulses = 0;
    int       capCount = 0;
    int       handCount = 0;

    // ========================================================================
    // DUT and bound checker
    // ========================================================================

    pecColumn #(
        .RamAddrWidth (RamAddrWidth)
    ) i_pecColumn (
        .clk       (clk),
        .rst_n     (rst_n),
        .rdyWei    (rdyWei),
        .getWei    (getWei),
        .weiIn     (weiIn),
        .lstRdy    (lstRdy),
        .lstBeat   (lstBeat),
        .lstGet    (lstGet),
        .nxtRdy    (nxtRdy),
        .nxtBeat   (nxtBeat),
        .nxtGet    (nxtGet),
        .ramEnRd   (ramEnRd),
        .ramAddrRd (ramAddrRd),
        .ramRdData (ramRdData),
        .ramEnWr   (ramEnWr),
        .ramAddrWr (ramAddrWr),
        .ramWrData (ramWrData)
    );

    bind pecColumn pecCheck_sva i_pecCheck_sva (
        .clk     (clk),
        .rst_n   (rst_n),
        .rdyWei  (rdyWei),
        .getWei  (getWei),
        .lstRdy  (lstRdy),
        .lstGet  (lstGet),
        .nxtRdy  (nxtRdy),
        .nxtGet  (nxtGet),
        .ramEnRd (ramEnRd),
        .ramEnWr (ramEnWr)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================

    // Flagged dot product, a pair counts only when both flags are set
    function automatic int dotRef(input actBeat_t b, input elem_t [BlockDepth-1:0] w,
                                  input logic [BlockDepth-1:0] wf);
        int acc;
        acc = 0;
        for (int i = 0; i < BlockDepth; i++) begin
            if (b.flags[i] && wf[i]) begin
                acc += int'(signed'(b.act[i])) * int'(signed'(w[i]));
            end
        end
        return acc;
    endfunction

    // RAM value plus, per kernel row, tap 2 of now, tap 1 of one back, tap 0 of two back
    function automatic psum_t expectWrite(input weiSet_t w, input actBeat_t win [3],
                                          input int depth, input psum_t ramVal);
        int sum;
        int tapIdx;
        sum = int'(ramVal);
        for (int r = 0; r < RowTaps; r++) begin
            for (int back = 0; back < depth; back++) begin
                tapIdx = r * RowTaps + (RowTaps - 1 - back);
                sum += dotRef(win[back], w.wei[tapIdx], w.flags[tapIdx]);
            end
        end
        return psum_t'(sum);
    endfunction

    // ========================================================================
    // Stimulus
    // ========================================================================

    function automatic actBeat_t randomBeat(input int col, input bit endBlock);
        actBeat_t b;
        b.firstRow  = (col == 0);
        b.lastRow   = (col == BeatsPerRow - 1);
        b.lastBlock = b.lastRow && endBlock;
        // Mostly real data, some skipped writes and empty columns
        b.valPsum   = ($random(seed) % 4) != 0;
        b.valCol    = ($random(seed) % 8) != 0;
        b.flags     = BlockDepth'($random(seed));
        for (int i = 0; i < BlockDepth; i++) begin
            b.act[i] = elem_t'($random(seed));
        end
        return b;
    endfunction

    task automatic loadWeights();
        weiSet_t w;
        for (int k = 0; k < KernelSize; k++) begin
            for (int i = 0; i < BlockDepth; i++) begin
                w.wei[k][i] = elem_t'($random(seed));
            end
            w.flags[k] = BlockDepth'($random(seed));
        end
        curWei = w;
        weiIn  <= w;
        rdyWei <= 1'b1;
        do begin
            @(posedge clk);
            assert (!lstGet) else stopOnError("Activation was taken before weights were held");
        end while (!getWei);
        rdyWei <= 1'b0;
    endtask

    // Expected read and write are queued before the beat is offered
    task automatic sendBeat(input actBeat_t b);
        psum_t ramVal;
        psum_t wrVal;
        if (b.firstRow) begin
            histDepth = 0;
        end
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = b;
        if (histDepth < 3) begin
            histDepth++;
        end
        ramVal = '0;
        if (b.valCol) begin
            ramVal = shadowMem[rdAddr];
            expRdAddr.push_back(rdAddr);
            rdAddr++;
        end
        wrVal = expectWrite(curWei, hist, histDepth, ramVal);
        if (b.valPsum && b.valCol) begin
            expWrAddr.push_back(wrAddr);
            expWrData.push_back(wrVal);
            shadowMem[wrAddr] = wrVal;
            wrAddr++;
        end
        // Block end restarts both counters
        if (b.lastBlock) begin
            rdAddr = 0;
            wrAddr = 0;
        end
        sentQ.push_back(b);
        lstBeat <= b;
        lstRdy  <= 1'b1;
        do @(posedge clk); while (!lstGet);
    endtask

    initial begin : stimulus
        actBeat_t b;
        rst_n   <= 1'b0;
        rdyWei  <= 1'b0;
        weiIn   <= '0;
        lstRdy  <= 1'b0;
        lstBeat <= '0;
        histDepth = 0;
        rdAddr    = 0;
        wrAddr    = 0;
        for (int a = 0; a < RamDepth; a++) begin
            shadowMem[a] = psum_t'($random(seed));
        end
        for (int n = 0; n < TotalBeats; n++) begin
            getDelay[n] = $unsigned($random(seed)) % 4;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int blk = 0; blk < NumBlocks; blk++) begin
            for (int row = 0; row < RowsPerBlock; row++) begin
                for (int col = 0; col < BeatsPerRow; col++) begin
                    b = randomBeat(col, row == RowsPerBlock - 1);
                    // First beat offered early, must wait for weights
                    if (row == 0 && col == 0) begin
                        lstBeat <= b;
                        lstRdy  <= 1'b1;
                        repeat (5) begin
                            @(posedge clk);
                            assert (!lstGet)
                                else stopOnError("Activation was taken with no weights loaded");
                        end
                        loadWeights();
                    end
                    sendBeat(b);
                end
            end
        end
        lstRdy <= 1'b0;
        while (sentQ.size() != 0 || expRdAddr.size() != 0 || expWrAddr.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (weiPulses == NumBlocks) begin
            $display("Everything OK");
            $finish;
        end else begin
            stopOnError($sformatf("getWei pulsed %0d times for %0d weight loads",
                                  weiPulses, NumBlocks));
        end
    end

    // ========================================================================
    // Models and checkers
    // ========================================================================

    // Partial-sum RAM, read data one cycle after the enable
    initial begin : ramModel
        ramRdData <= '0;
        @(posedge clk);
        foreach (ramMem[a]) begin
            ramMem[a] = shadowMem[a];
        end
        forever begin
            @(posedge clk);
            if (ramEnWr) begin
                ramMem[ramAddrWr] <= ramWrData;
            end
            if (ramEnRd) begin
                ramRdData <= ramMem[ramAddrRd];
            end
        end
    end

    // Next column, takes a held beat after 0 to 3 cycles
    initial begin : nextColumn
        int n;
        n = 0;
        nxtGet <= 1'b0;
        forever begin
            @(posedge clk);
            nxtGet <= 1'b0;
            if (nxtRdy && !nxtGet) begin
                repeat (getDelay[n % TotalBeats]) @(posedge clk);
                n++;
                nxtGet <= 1'b1;
            end
        end
    end

    // Strobe counts, back-pressure and forwarding order
    initial begin : monitorBeats
        forever begin
            @(posedge clk);
            if (getWei) begin
                weiPulses++;
            end
            if (lstGet) begin
                assert (capCount == handCount)
                    else stopOnError("lstGet pulsed while a beat was still held for the next column");
                capCount++;
            end
            if (nxtRdy) begin
                assert (sentQ.size() > 0) else stopOnError("nxtRdy raised with no beat sent");
                assert (nxtBeat == sentQ[0])
                    else stopOnError($sformatf("[ERROR] nxtBeat = %h, expected %h",
                                               nxtBeat, sentQ[0]));
                if (nxtGet) begin
                    void'(sentQ.pop_front());
                    handCount++;
                end
            end
        end
    end

    // RAM traffic against the reference
    initial begin : compareRam
        forever begin
            @(posedge clk);
            if (ramEnRd) begin
                assert (expRdAddr.size() > 0) else stopOnError("RAM read for a beat that has none");
                assert (int'(ramAddrRd) == expRdAddr[0])
                    else stopOnError($sformatf("[ERROR] ramAddrRd = %h, expected %h",
                                               ramAddrRd, expRdAddr[0]));
                void'(expRdAddr.pop_front());
            end
            if (ramEnWr) begin
                assert (expWrAddr.size() > 0) else stopOnError("RAM write for a beat that has none");
                assert (int'(ramAddrWr) == expWrAddr[0])
                    else stopOnError($sformatf("[ERROR] ramAddrWr = %h, expected %h",
                                               ramAddrWr, expWrAddr[0]));
                assert (ramWrData == expWrData[0])
                    else stopOnError($sformatf("[ERROR] ramWrData = %h, expected %h",
                                               ramWrData, expWrData[0]));
                void'(expWrAddr.pop_front());
                void'(expWrData.pop_front());
            end
        end
    end

    // Roughly 15 cycles per beat in the worst case, 40 leaves margin
    initial begin : watchdog
        repeat (TotalBeats * 40 + 200) @(posedge clk);
        stopOnError("Watchdog expired before all beats were processed");
    end

endmodule

`default_nettype wire

// ==== tests/pecCheck_sva.sv ====
// Strobe checks bound into pecColumn; checks are off while rst_n is low
`default_nettype none
`timescale 1ns/1ps

module pecCheck_sva (
    input logic clk,
    input logic rst_n,
    input logic rdyWei,
    input logic getWei,
    input logic lstRdy,
    input logic lstGet,
    input logic nxtRdy,
    input logic nxtGet,
    input logic ramEnRd,
    input logic ramEnWr
);

    // Weight strobe one cycle wide, spacer cycle before any capture
    getWeiSpacer: assert property (@(posedge clk) disable iff (!rst_n) getWei |=> !lstGet)
        else $error("lstGet right after getWei");
    getWeiPulse: assert property (@(posedge clk) disable iff (!rst_n) getWei |=> !getWei)
        else $error("getWei longer than one cycle");

    // Captured beat offered to the next column at once
    lstGetForward: assert property (@(posedge clk) disable iff (!rst_n)
        lstGet |=> nxtRdy)
        else $error("nxtRdy not raised after lstGet");
    lstGetPulse: assert property (@(posedge clk) disable iff (!rst_n) lstGet |=> !lstGet)
        else $error("lstGet longer than one cycle");

    // Held beat stays offered until taken
    nxtRdyHeld: assert property (@(posedge clk) disable iff (!rst_n)
        nxtRdy && !nxtGet |=> nxtRdy)
        else $error("nxtRdy dropped before nxtGet");

    // Read one cycle after capture, write strobe single cycle
    readAfterGet: assert property (@(posedge clk) disable iff (!rst_n) ramEnRd |-> $past(lstGet))
        else $error("ramEnRd not one cycle after lstGet");
    writePulse: assert property (@(posedge clk) disable iff (!rst_n) ramEnWr |=> !ramEnWr)
        else $error("ramEnWr longer than one cycle");

endmodule

`default_nettype wire

// ==== rtl/pecColumn.sv ====
// PE column top; all three kernel rows see the same activation stream, no vertical sliding
`default_nettype none
`timescale 1ns/1ps

module pecColumn
    import pecDimPkg::*;
    import pecBusPkg::*;
#(
    parameter int RamAddrWidth = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Weight source
    input  logic                    rdyWei,
    output logic                    getWei,
    input  weiSet_t                 weiIn,
    // Previous column
    input  logic                    lstRdy,
    input  actBeat_t                lstBeat,
    output logic                    lstGet,
    // Next column
    output logic                    nxtRdy,
    output actBeat_t                nxtBeat,
    input  logic                    nxtGet,
    // Partial-sum RAM
    output logic                    ramEnRd,
    output logic [RamAddrWidth-1:0] ramAddrRd,
    input  psum_t                   ramRdData,
    output logic                    ramEnWr,
    output logic [RamAddrWidth-1:0] ramAddrWr,
    output psum_t                   ramWrData
);

    weiSet_t              weiHeld;
    logic                 macStart;
    logic                 accDone;
    logic  [RowTaps-1:0]  rowDone;
    // Row chain, index RowTaps is the RAM read value
    psum_t [RowTaps:0]    psumChain;

    // =========================================================================
    // Control and weights
    // =========================================================================

    // Registered beat feeds the rows and the next column
    pecControl i_pecControl (
        .clk      (clk),
        .rst_n    (rst_n),
        .rdyWei   (rdyWei),
        .getWei   (getWei),
        .lstRdy   (lstRdy),
        .lstBeat  (lstBeat),
        .lstGet   (lstGet),
        .nxtGet   (nxtGet),
        .nxtRdy   (nxtRdy),
        .beat     (nxtBeat),
        .macStart (macStart),
        .allDone  (),
        .accDone  (accDone),
        .rowDone  (rowDone)
    );

    weightBank i_weightBank (
        .clk    (clk),
        .rst_n  (rst_n),
        .getWei (getWei),
        .weiIn  (weiIn),
        .weiOut (weiHeld)
    );

    // =========================================================================
    // Kernel rows, chained from row 2 down to row 0
    // =========================================================================

    for (genvar r = 0; r < RowTaps; r++) begin : gRow
        convRow i_convRow (
            .clk      (clk),
            .rst_n    (rst_n),
            .macStart (macStart),
            .accDone  (accDone),
            .beat     (nxtBeat),
            .weiRow   (weiHeld.wei[r*RowTaps +: RowTaps]),
            .flgRow   (weiHeld.flags[r*RowTaps +: RowTaps]),
            .psumIn   (psumChain[r+1]),
            .rowDone  (rowDone[r]),
            .psumOut  (psumChain[r])
        );
    end

    // RAM port closes the chain, row 0 result is written back
    psumRamPort #(
        .RamAddrWidth (RamAddrWidth)
    ) i_psumRamPort (
        .clk       (clk),
        .rst_n     (rst_n),
        .macStart  (macStart),
        .accDone   (accDone),
        .beat      (nxtBeat),
        .rowPsum   (psumChain[0]),
        .psumRd    (psumChain[RowTaps]),
        .ramEnRd   (ramEnRd),
        .ramAddrRd (ramAddrRd),
        .ramRdData (ramRdData),
        .ramEnWr   (ramEnWr),
        .ramAddrWr (ramAddrWr),
        .ramWrData (ramWrData)
    );

endmodule

`default_nettype wire

// ==== rtl/psumRamPort.sv ====
// Partial-sum RAM port; RAM read latency must be exactly one cycle, addresses wrap at 2**width
`default_nettype none
`timescale 1ns/1ps

module psumRamPort
    import pecDimPkg::*;
    import pecBusPkg::*;
#(
    parameter int RamAddrWidth = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    macStart,
    input  logic                    accDone,
    input  actBeat_t                beat,
    input  psum_t                   rowPsum,
    output psum_t                   psumRd,
    output logic                    ramEnRd,
    output logic [RamAddrWidth-1:0] ramAddrRd,
    input  psum_t                   ramRdData,
    output logic                    ramEnWr,
    output logic [RamAddrWidth-1:0] ramAddrWr,
    output psum_t                   ramWrData
);

    // Read issued last cycle, data on ramRdData now
    logic rdPending;
    // Block end, counters restart
    logic addrClr;

    // =========================================================================
    // Read side
    // =========================================================================

    assign ramEnRd = macStart && beat.valCol;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPending <= 1'b0;
        end else begin
            rdPending <= ramEnRd;
        end
    end

    // Row 2 chain input, empty column contributes zero
    always_ff @(posedge clk) begin
        if (rdPending) begin
            psumRd <= ramRdData;
        end else if (macStart && !beat.valCol) begin
            psumRd <= '0;
        end
    end

    // =========================================================================
    // Write side
    // =========================================================================

    // Write one cycle after accumulate done, data and enable together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramEnWr <= 1'b0;
        end else begin
            ramEnWr <= accDone && beat.valPsum && beat.valCol;
        end
    end

    always_ff @(posedge clk) begin
        if (accDone) begin
            ramWrData <= rowPsum;
        end
    end

    // Address counters
    // The clear lands on the edge of the last write, so that write keeps its address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addrClr <= 1'b0;
        end else begin
            addrClr <= accDone && beat.lastBlock;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramAddrRd <= '0;
            ramAddrWr <= '0;
        end else if (addrClr) begin
            ramAddrRd <= '0;
            ramAddrWr <= '0;
        end else begin
            if (ramEnRd) begin
                ramAddrRd <= ramAddrRd + 1'b1;
            end
            if (ramEnWr) begin
                ramAddrWr <= ramAddrWr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pecControl.sv ====
// Column FSM; rdyWei and lstRdy are levels with stable data, nxtGet held low is back-pressure
`default_nettype none
`timescale 1ns/1ps

module pecControl
    import pecDimPkg::*;
    import pecBusPkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rdyWei,
    output logic               getWei,
    input  logic               lstRdy,
    input  actBeat_t           lstBeat,
    output logic               lstGet,
    input  logic               nxtGet,
    output logic               nxtRdy,
    output actBeat_t           beat,
    output logic               macStart,
    output logic               allDone,
    output logic               accDone,
    input  logic [RowTaps-1:0] rowDone
);

    pecState_t state;
    pecState_t nextState;
    // Done level one cycle back, for edge detect
    logic      allDoneD;

    // =========================================================================
    // State machine
    // =========================================================================

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                nextState = WAITWEI;
            end
            WAITWEI: begin
                if (rdyWei) begin
                    nextState = READRAM;
                end
            end
            // One cycle spacer before activations
            READRAM: begin
                nextState = WAITACT;
            end
            // Take a beat only when all MACs are idle
            WAITACT: begin
                if (lstRdy && allDone) begin
                    nextState = WAITGET;
                end
            end
            // Hold the beat until the next column takes it
            WAITGET: begin
                if (nxtGet) begin
                    nextState = beat.lastRow ? WRITERAM : WAITACT;
                end
            end
            WRITERAM: begin
                nextState = beat.lastBlock ? IDLE : READRAM;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Handshake strobes
    assign getWei = (state == WAITWEI) && rdyWei;
    assign lstGet = (state == WAITACT) && lstRdy && allDone;
    assign nxtRdy = (state == WAITGET);

    // =========================================================================
    // Activation register and MAC strobes
    // =========================================================================

    // Beat goes to MACs and to next column together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (lstGet) begin
            beat <= lstBeat;
        end
    end

    // Start one cycle after capture, once the beat is registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            macStart <= 1'b0;
        end else begin
            macStart <= lstGet;
        end
    end

    assign allDone = &rowDone;

    // Reset value high, no false edge out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            allDoneD <= 1'b1;
        end else begin
            allDoneD <= allDone;
        end
    end

    // Rising edge of the done level
    assign accDone = allDone && !allDoneD;

endmodule

`default_nettype wire

// ==== rtl/weightBank.sv ====
// Weight register bank; weiIn must be stable in the getWei cycle, held until the next getWei
`default_nettype none
`timescale 1ns/1ps

module weightBank
    import pecBusPkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    getWei,
    input  weiSet_t weiIn,
    output weiSet_t weiOut
);

    // Whole set replaced at once
    // Zero weights with cleared flags after reset, so no pair is ever taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiOut <= '0;
        end else if (getWei) begin
            weiOut <= weiIn;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/convRow.sv ====
// One kernel row; history window is valid only after a firstRow beat, beats must stay in order
`default_nettype none
`timescale 1ns/1ps

module convRow
    import pecDimPkg::*;
    import pecBusPkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                macStart,
    input  logic                                accDone,
    input  actBeat_t                            beat,
    input  elem_t [RowTaps-1:0][BlockDepth-1:0] weiRow,
    input  logic  [RowTaps-1:0][BlockDepth-1:0] flgRow,
    input  psum_t                               psumIn,
    output logic                                rowDone,
    output psum_t                               psumOut
);

    logic  [RowTaps-1:0] macDone;
    psum_t [RowTaps-1:0] tap;
    // Tap 0 of previous beat
    psum_t winPrev;
    // Tap 1 of previous beat plus tap 0 of the beat before
    psum_t winSum;
    // Window as seen by the current beat
    psum_t histPrev;
    psum_t histSum;

    // =========================================================================
    // Tap MACs
    // =========================================================================

    for (genvar k = 0; k < RowTaps; k++) begin : gTap
        sparseMac i_sparseMac (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (macStart),
            .act      (beat.act),
            .actFlags (beat.flags),
            .wei      (weiRow[k]),
            .weiFlags (flgRow[k]),
            .done     (macDone[k]),
            .product  (tap[k])
        );
    end

    // Row idle only when every tap is idle
    assign rowDone = &macDone;

    // =========================================================================
    // 3-tap sliding sum
    // =========================================================================

    // First beat of a row sees an empty window
    assign histPrev = beat.firstRow ? '0 : winPrev;
    assign histSum  = beat.firstRow ? '0 : winSum;

    // Chain input plus tap 2 now, tap 1 one back, tap 0 two back
    assign psumOut = psumIn + tap[2] + histSum;

    // Shift on accumulate done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            winPrev <= '0;
            winSum  <= '0;
        end else if (accDone) begin
            winPrev <= tap[0];
            winSum  <= tap[1] + histPrev;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sparseMac.sv ====
// Sparse MAC; operands must hold still until done, one cycle per flagged pair, minimum one
`default_nettype none
`timescale 1ns/1ps

module sparseMac
    import pecDimPkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  elem_t [BlockDepth-1:0] act,
    input  logic  [BlockDepth-1:0] actFlags,
    input  elem_t [BlockDepth-1:0] wei,
    input  logic  [BlockDepth-1:0] weiFlags,
    output logic                   done,
    output psum_t                  product
);

    // Pairs still to be multiplied
    logic [BlockDepth-1:0] pending;
    // Lowest pending pair, one-hot
    logic [BlockDepth-1:0] lowBit;
    logic                  busy;
    // Product of the selected pair
    psum_t                 term;

    // Isolate lowest set bit
    assign lowBit = pending & (~pending + 1'b1);

    // One-hot mux of the selected product, zero when nothing pending
    always_comb begin
        term = '0;
        for (int i = 0; i < BlockDepth; i++) begin
            if (lowBit[i]) begin
                term = psum_t'(act[i]) * psum_t'(wei[i]);
            end
        end
    end

    // Pair scheduler
    // busy drops in the cycle after the last pair is consumed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            pending <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            pending <= actFlags & weiFlags;
        end else if (busy) begin
            pending <= pending & ~lowBit;
            busy    <= |(pending & ~lowBit);
        end
    end

    // Accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (start) begin
            product <= '0;
        end else if (busy) begin
            product <= product + term;
        end
    end

    assign done = !busy;

endmodule

`default_nettype wire

// ==== rtl/pecBusPkg.sv ====
// Bus and state types of the column; flag bit i always qualifies element i of the same vector
`default_nettype none

package pecBusPkg;

    import pecDimPkg::*;

    // =========================================================================
    // Activation beat between neighbouring columns
    // =========================================================================

    typedef struct packed {
        // Row position flags
        logic                   firstRow;
        logic                   lastRow;
        // Last beat of a block, addresses restart afterwards
        logic                   lastBlock;
        // Partial sum is to be written back
        logic                   valPsum;
        // Column holds real data, gates read and write
        logic                   valCol;
        // Nonzero marks, one per element
        logic  [BlockDepth-1:0] flags;
        elem_t [BlockDepth-1:0] act;
    } actBeat_t;

    // =========================================================================
    // Weight set for one kernel
    // =========================================================================

    // Vector k is tap k, row-major over the 3x3 kernel
    typedef struct packed {
        elem_t [KernelSize-1:0][BlockDepth-1:0] wei;
        logic  [KernelSize-1:0][BlockDepth-1:0] flags;
    } weiSet_t;

    // =========================================================================
    // Control FSM states
    // =========================================================================

    typedef enum logic [2:0] {
        IDLE     = 3'b000,
        WAITWEI  = 3'b001,
        WAITACT  = 3'b011,
        WAITGET  = 3'b010,
        READRAM  = 3'b100,
        WRITERAM = 3'b101
    } pecState_t;

endpackage

`default_nettype wire

// ==== rtl/pecDimPkg.sv ====
// Element, vector and partial-sum dimensions; widths must leave PsumWidth room for all sums
`default_nettype none

package pecDimPkg;

    // =========================================================================
    // Vector geometry
    // =========================================================================

    // Bits per activation or weight element
    localparam int DataWidth  = 8;
    // Elements carried in one sparse vector
    localparam int BlockDepth = 4;
    // Taps of a full 3x3 kernel
    localparam int KernelSize = 9;
    // Taps of one kernel row
    localparam int RowTaps    = 3;

    // =========================================================================
    // Arithmetic widths
    // =========================================================================

    // Partial sum, wide enough for 9 taps of 4 products plus RAM value
    localparam int PsumWidth  = 24;

    // One signed operand element
    typedef logic signed [DataWidth-1:0] elem_t;

    // One signed partial sum
    typedef logic signed [PsumWidth-1:0] psum_t;

endpackage

`default_nettype wire
